//--- common/exu_pkg.sv
package exu_pkg;

  typedef logic [31:0] word_t;

  typedef logic [3:0] alu_op_t;
  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_AND  = 4'd2;
  localparam alu_op_t ALU_OR   = 4'd3;
  localparam alu_op_t ALU_XOR  = 4'd4;
  localparam alu_op_t ALU_SLL  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;
  localparam alu_op_t ALU_SLT  = 4'd8;
  localparam alu_op_t ALU_SLTU = 4'd9;
  localparam alu_op_t ALU_EQ   = 4'd10; // Branch compares from here on.
  localparam alu_op_t ALU_NE   = 4'd11;
  localparam alu_op_t ALU_LT   = 4'd12;
  localparam alu_op_t ALU_GE   = 4'd13;
  localparam alu_op_t ALU_LTU  = 4'd14;
  localparam alu_op_t ALU_GEU  = 4'd15;

  typedef logic [1:0] opnd_sel_t;
  localparam opnd_sel_t OPND_REG    = 2'd0;
  localparam opnd_sel_t OPND_IMM    = 2'd1; // Operand 2 only.
  localparam opnd_sel_t OPND_BYPASS = 2'd2;
  localparam opnd_sel_t OPND_FWD    = 2'd3;

  typedef logic [1:0] npc_sel_t;
  localparam npc_sel_t NPC_SEQ    = 2'd0;
  localparam npc_sel_t NPC_JAL    = 2'd1;
  localparam npc_sel_t NPC_JALR   = 2'd2;
  localparam npc_sel_t NPC_BRANCH = 2'd3;

  typedef logic [1:0] wb_sel_t;
  localparam wb_sel_t WB_ALU  = 2'd0;
  localparam wb_sel_t WB_SNPC = 2'd1; // Link address for jal and jalr.
  localparam wb_sel_t WB_DNPC = 2'd2; // The auipc result.
  localparam wb_sel_t WB_CSR  = 2'd3;

  typedef enum logic {
    ST_RUN,
    ST_FENCE
  } exu_state_t;

  // Defaults for the fence length and the width of its counter.
  localparam int DEFAULT_FENCE_CYCLES = 4;
  localparam int DEFAULT_TIMER_WIDTH  = 3;

endpackage

//--- common/exu_stage_if.sv
interface exu_stage_if;

  exu_pkg::alu_op_t  op;
  exu_pkg::word_t    operand1;
  exu_pkg::word_t    operand2;
  exu_pkg::word_t    pc;
  exu_pkg::word_t    snpc;
  exu_pkg::word_t    dnpc;
  exu_pkg::word_t    csr;
  exu_pkg::npc_sel_t npc_sel;
  exu_pkg::wb_sel_t  wb_sel;
  logic              valid;

  modport producer (
    output op, operand1, operand2,
    output pc, snpc, dnpc, csr,
    output npc_sel, wb_sel, valid
  );

  modport consumer (
    input op, operand1, operand2,
    input pc, snpc, dnpc, csr,
    input npc_sel, wb_sel, valid
  );

endinterface

//--- source/alu.sv
module alu (
  input  exu_pkg::alu_op_t op,
  input  exu_pkg::word_t   operand1,
  input  exu_pkg::word_t   operand2,
  output exu_pkg::word_t   result
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;
  logic       equal;

  assign shamt       = operand2[4:0];
  assign lt_signed   = $signed(operand1) < $signed(operand2);
  assign lt_unsigned = operand1 < operand2;
  assign equal       = operand1 == operand2;

  always_comb begin
    result = '0;
    case (op)
      exu_pkg::ALU_ADD:  result = operand1 + operand2;
      exu_pkg::ALU_SUB:  result = operand1 - operand2;
      exu_pkg::ALU_AND:  result = operand1 & operand2;
      exu_pkg::ALU_OR:   result = operand1 | operand2;
      exu_pkg::ALU_XOR:  result = operand1 ^ operand2;
      exu_pkg::ALU_SLL:  result = operand1 << shamt;
      exu_pkg::ALU_SRL:  result = operand1 >> shamt;
      exu_pkg::ALU_SRA:  result = $signed(operand1) >>> shamt;
      exu_pkg::ALU_SLT:  result = {31'd0, lt_signed};
      exu_pkg::ALU_SLTU: result = {31'd0, lt_unsigned};
      exu_pkg::ALU_EQ:   result = {31'd0, equal}; // Bit 0 is the branch decision.
      exu_pkg::ALU_NE:   result = {31'd0, !equal};
      exu_pkg::ALU_LT:   result = {31'd0, lt_signed};
      exu_pkg::ALU_GE:   result = {31'd0, !lt_signed};
      exu_pkg::ALU_LTU:  result = {31'd0, lt_unsigned};
      exu_pkg::ALU_GEU:  result = {31'd0, !lt_unsigned};
      default:           result = '0;
    endcase
  end

endmodule

//--- source/operand_select.sv
module operand_select (
  input  logic               clock,
  input  logic               reset,
  input  logic               advance,
  input  logic               accept,
  input  exu_pkg::alu_op_t   op,
  input  exu_pkg::opnd_sel_t opnd1_sel,
  input  exu_pkg::opnd_sel_t opnd2_sel,
  input  exu_pkg::word_t     src1,
  input  exu_pkg::word_t     src2,
  input  exu_pkg::word_t     imm,
  input  exu_pkg::word_t     forward_data,
  input  exu_pkg::word_t     pc,
  input  exu_pkg::word_t     csr_src,
  input  exu_pkg::npc_sel_t  npc_sel,
  input  exu_pkg::wb_sel_t   wb_sel,
  input  exu_pkg::word_t     wb_value,
  exu_stage_if.producer      stage
);

  exu_pkg::word_t operand1;
  exu_pkg::word_t operand2;

  // The bypass path returns the result of the instruction now in the stage register.
  function automatic exu_pkg::word_t pick(
    input exu_pkg::opnd_sel_t sel,
    input exu_pkg::word_t     reg_value,
    input exu_pkg::word_t     imm_value
  );
    case (sel)
      exu_pkg::OPND_IMM:    pick = imm_value;
      exu_pkg::OPND_BYPASS: pick = wb_value;
      exu_pkg::OPND_FWD:    pick = forward_data;
      default:              pick = reg_value;
    endcase
  endfunction

  always_comb begin
    operand1 = pick(opnd1_sel, src1, src1); // No immediate on this side.
    operand2 = pick(opnd2_sel, src2, imm);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      stage.valid <= 1'b0;
    end else if (advance) begin
      stage.valid <= accept;
    end
  end

  always_ff @(posedge clock) begin
    if (advance) begin
      stage.op       <= op;
      stage.operand1 <= operand1;
      stage.operand2 <= operand2;
      stage.pc       <= pc;
      stage.snpc     <= pc + 32'd4;
      stage.dnpc     <= pc + imm; // The jump and branch target is also the auipc value.
      stage.csr      <= csr_src;
      stage.npc_sel  <= npc_sel;
      stage.wb_sel   <= wb_sel;
    end
  end

endmodule

//--- source/next_pc.sv
module next_pc (
  exu_stage_if.consumer  stage,
  input  exu_pkg::word_t alu_result,
  output exu_pkg::word_t npc,
  output exu_pkg::word_t wb_value
);

  logic taken;

  assign taken = alu_result[0]; // Compare ops leave the decision in bit 0.

  always_comb begin
    case (stage.npc_sel)
      exu_pkg::NPC_SEQ: begin
        npc = stage.snpc;
      end
      exu_pkg::NPC_JAL: begin
        npc = stage.dnpc;
      end
      exu_pkg::NPC_JALR: begin
        npc = {alu_result[31:1], 1'b0};
      end
      default: begin
        npc = taken ? stage.dnpc : stage.snpc;
      end
    endcase
  end

  always_comb begin
    case (stage.wb_sel)
      exu_pkg::WB_ALU: begin
        wb_value = alu_result;
      end
      exu_pkg::WB_SNPC: begin
        wb_value = stage.snpc;
      end
      exu_pkg::WB_DNPC: begin
        wb_value = stage.dnpc;
      end
      default: begin
        wb_value = stage.csr;
      end
    endcase
  end

endmodule

//--- control/exu_control.sv
module exu_control #(
  parameter int FENCE_CYCLES = exu_pkg::DEFAULT_FENCE_CYCLES
) (
  input  logic clock,
  input  logic reset,
  input  logic block,
  input  logic decode_valid,
  input  logic fence_i,
  input  logic exception,
  input  logic redirect,
  input  logic timer_busy,
  output logic accept,
  output logic advance,
  output logic timer_start,
  output logic npc_valid,
  output logic clear_pipeline,
  output logic clear_cache
);

  exu_pkg::exu_state_t state;
  exu_pkg::exu_state_t state_next;

  assign advance        = !block;
  assign clear_cache    = (state == exu_pkg::ST_FENCE) && (FENCE_CYCLES > 0);
  assign clear_pipeline = redirect || clear_cache;

  // An instruction behind a taken transfer or a fence is squashed here.
  assign accept = (state == exu_pkg::ST_RUN) && decode_valid && !exception
                  && !clear_pipeline;

  assign timer_start = accept && fence_i;

  always_comb begin
    state_next = state;
    case (state)
      exu_pkg::ST_RUN: begin
        if (timer_start) begin
          state_next = exu_pkg::ST_FENCE;
        end
      end
      default: begin
        if (!timer_busy) begin
          state_next = exu_pkg::ST_RUN;
        end
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= exu_pkg::ST_RUN;
      npc_valid <= 1'b0;
    end else if (advance) begin
      state     <= state_next;
      npc_valid <= accept;
    end
  end

endmodule

//--- control/fence_timer.sv
module fence_timer #(
  parameter int FENCE_CYCLES = exu_pkg::DEFAULT_FENCE_CYCLES,
  parameter int TIMER_WIDTH  = exu_pkg::DEFAULT_TIMER_WIDTH
) (
  input  logic clock,
  input  logic reset,
  input  logic hold,
  input  logic start,
  output logic busy
);

  logic [TIMER_WIDTH-1:0] count;

  // The cycle that enters the fence state is the first fence cycle.
  localparam logic [TIMER_WIDTH-1:0] LOAD_VALUE =
    (FENCE_CYCLES > 1) ? TIMER_WIDTH'(FENCE_CYCLES - 1) : '0;

  assign busy = count != '0;

  always_ff @(posedge clock) begin
    if (reset) begin
      count <= '0;
    end else if (!hold) begin
      if (start) begin
        count <= LOAD_VALUE;
      end else if (busy) begin
        count <= count - TIMER_WIDTH'(1);
      end
    end
  end

endmodule

//--- source/execute_top.sv
module execute_top #(
  parameter int FENCE_CYCLES = exu_pkg::DEFAULT_FENCE_CYCLES,
  parameter int TIMER_WIDTH  = exu_pkg::DEFAULT_TIMER_WIDTH
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               block,
  input  logic               decode_valid,
  input  logic               fence_i,
  input  logic               exception,
  input  exu_pkg::word_t     idu_pc,
  input  exu_pkg::word_t     imm,
  input  exu_pkg::word_t     src1,
  input  exu_pkg::word_t     src2,
  input  exu_pkg::word_t     forward_data,
  input  exu_pkg::word_t     csr_src,
  input  exu_pkg::alu_op_t   alu_op,
  input  exu_pkg::opnd_sel_t opnd1_sel,
  input  exu_pkg::opnd_sel_t opnd2_sel,
  input  exu_pkg::npc_sel_t  npc_sel,
  input  exu_pkg::wb_sel_t   wb_sel,
  output exu_pkg::word_t     exu_pc,
  output exu_pkg::word_t     alu_result,
  output exu_pkg::word_t     npc,
  output exu_pkg::word_t     snpc,
  output exu_pkg::word_t     exu_r_wdata,
  output logic               npc_valid,
  output logic               clear_pipeline,
  output logic               clear_cache
);

  logic accept;
  logic advance;
  logic timer_start;
  logic timer_busy;
  logic redirect;

  exu_stage_if stage ();

  assign redirect = stage.valid && (stage.npc_sel != exu_pkg::NPC_SEQ);
  assign exu_pc   = stage.pc;
  assign snpc     = stage.snpc;

  operand_select u_operand_select (
    .clock(clock), .reset(reset), .advance(advance), .accept(accept),
    .op(alu_op), .opnd1_sel(opnd1_sel), .opnd2_sel(opnd2_sel),
    .src1(src1), .src2(src2), .imm(imm), .forward_data(forward_data),
    .pc(idu_pc), .csr_src(csr_src), .npc_sel(npc_sel), .wb_sel(wb_sel),
    .wb_value(exu_r_wdata), .stage(stage.producer)
  );

  alu u_alu (
    .op(stage.op), .operand1(stage.operand1), .operand2(stage.operand2),
    .result(alu_result)
  );

  next_pc u_next_pc (
    .stage(stage.consumer), .alu_result(alu_result), .npc(npc), .wb_value(exu_r_wdata)
  );

  exu_control #(.FENCE_CYCLES(FENCE_CYCLES)) u_exu_control (
    .clock(clock), .reset(reset), .block(block), .decode_valid(decode_valid),
    .fence_i(fence_i), .exception(exception), .redirect(redirect),
    .timer_busy(timer_busy), .accept(accept), .advance(advance),
    .timer_start(timer_start), .npc_valid(npc_valid),
    .clear_pipeline(clear_pipeline), .clear_cache(clear_cache)
  );

  fence_timer #(.FENCE_CYCLES(FENCE_CYCLES), .TIMER_WIDTH(TIMER_WIDTH)) u_fence_timer (
    .clock(clock), .reset(reset), .hold(block), .start(timer_start), .busy(timer_busy)
  );

endmodule

//--- verification/execute_model.svh
`ifndef EXECUTE_MODEL_SVH
`define EXECUTE_MODEL_SVH

function automatic exu_pkg::word_t alu_ref(
  input exu_pkg::alu_op_t op,
  input exu_pkg::word_t   a,
  input exu_pkg::word_t   b
);
  logic signed [31:0] sa;
  logic signed [31:0] sb;
  exu_pkg::word_t     r;
  sa = a;
  sb = b;
  case (op)
    exu_pkg::ALU_ADD:                  r = a + b;
    exu_pkg::ALU_SUB:                  r = a + ~b + 32'd1; // Two's complement subtract.
    exu_pkg::ALU_AND:                  r = a & b;
    exu_pkg::ALU_OR:                   r = a | b;
    exu_pkg::ALU_XOR:                  r = a ^ b;
    exu_pkg::ALU_SLL:                  r = a << b[4:0];
    exu_pkg::ALU_SRL:                  r = a >> b[4:0];
    exu_pkg::ALU_SRA:                  r = sa >>> b[4:0];
    exu_pkg::ALU_SLT, exu_pkg::ALU_LT:  r = 32'(sa < sb);
    exu_pkg::ALU_SLTU, exu_pkg::ALU_LTU: r = 32'(a < b);
    exu_pkg::ALU_EQ:                   r = 32'(a == b);
    exu_pkg::ALU_NE:                   r = 32'(a != b);
    exu_pkg::ALU_GE:                   r = 32'(sa >= sb);
    exu_pkg::ALU_GEU:                  r = 32'(a >= b);
    default:                           r = '0;
  endcase
  return r;
endfunction

function automatic exu_pkg::word_t npc_ref(
  input exu_pkg::npc_sel_t sel,
  input exu_pkg::word_t    snpc,
  input exu_pkg::word_t    dnpc,
  input exu_pkg::word_t    alu
);
  if (sel == exu_pkg::NPC_JAL) return dnpc;
  if (sel == exu_pkg::NPC_JALR) return alu & ~32'd1; // Target of jalr has bit 0 cleared.
  if (sel == exu_pkg::NPC_BRANCH && alu[0]) return dnpc;
  return snpc;
endfunction

function automatic exu_pkg::word_t wb_ref(
  input exu_pkg::wb_sel_t sel,
  input exu_pkg::word_t   alu,
  input exu_pkg::word_t   snpc,
  input exu_pkg::word_t   dnpc,
  input exu_pkg::word_t   csr
);
  if (sel == exu_pkg::WB_SNPC) return snpc;
  if (sel == exu_pkg::WB_DNPC) return dnpc;
  if (sel == exu_pkg::WB_CSR) return csr;
  return alu;
endfunction

`endif

//--- verification/execute_tb.sv
module execute_tb;

  localparam int FENCE_CYCLES = 4;
  localparam int TIMER_WIDTH  = 3;
  localparam int RESET_CYCLES = 5;
  localparam int TEST_CYCLES  = 200 + 200 + 300 + 200 + 300 + 200;
  localparam int CYCLE_LIMIT  = 2 * (RESET_CYCLES + TEST_CYCLES);

  logic clock, reset, block, decode_valid, fence_i, exception;
  exu_pkg::word_t idu_pc, imm, src1, src2, forward_data, csr_src;
  exu_pkg::alu_op_t alu_op;
  exu_pkg::opnd_sel_t opnd1_sel, opnd2_sel;
  exu_pkg::npc_sel_t npc_sel;
  exu_pkg::wb_sel_t wb_sel;
  exu_pkg::word_t exu_pc, alu_result, npc, snpc, exu_r_wdata;
  logic npc_valid, clear_pipeline, clear_cache;

  logic m_valid, m_fence; // Expected stage register and control state.
  exu_pkg::alu_op_t m_op;
  exu_pkg::word_t m_opnd1, m_opnd2, m_pc, m_snpc, m_dnpc, m_csr;
  exu_pkg::npc_sel_t m_npc_sel;
  exu_pkg::wb_sel_t m_wb_sel;
  int m_fence_left, cycle_count, fence_len, fences_seen;
  logic [31:0] lcg_state;
  logic prev_cc, prev_block;
  exu_pkg::word_t held_alu, held_npc, held_wdata, held_pc;

  `include "execute_model.svh"

  execute_top #(.FENCE_CYCLES(FENCE_CYCLES), .TIMER_WIDTH(TIMER_WIDTH)) UUT (
    .clock(clock), .reset(reset), .block(block), .decode_valid(decode_valid),
    .fence_i(fence_i), .exception(exception), .idu_pc(idu_pc), .imm(imm),
    .src1(src1), .src2(src2), .forward_data(forward_data), .csr_src(csr_src),
    .alu_op(alu_op), .opnd1_sel(opnd1_sel), .opnd2_sel(opnd2_sel), .npc_sel(npc_sel),
    .wb_sel(wb_sel), .exu_pc(exu_pc), .alu_result(alu_result), .npc(npc), .snpc(snpc),
    .exu_r_wdata(exu_r_wdata), .npc_valid(npc_valid), .clear_pipeline(clear_pipeline),
    .clear_cache(clear_cache)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi[31:16], lo[31:16]}; // The low bits of an LCG repeat quickly.
  endfunction

  function automatic exu_pkg::word_t expected_wdata();
    return wb_ref(m_wb_sel, alu_ref(m_op, m_opnd1, m_opnd2), m_snpc, m_dnpc, m_csr);
  endfunction

  function automatic logic expected_flush();
    return (m_valid && m_npc_sel != exu_pkg::NPC_SEQ) || m_fence;
  endfunction

  function automatic exu_pkg::word_t select_operand(
    input exu_pkg::opnd_sel_t sel,
    input exu_pkg::word_t     reg_value,
    input exu_pkg::word_t     imm_value
  );
    if (sel == exu_pkg::OPND_IMM) return imm_value;
    if (sel == exu_pkg::OPND_BYPASS) return expected_wdata();
    if (sel == exu_pkg::OPND_FWD) return forward_data;
    return reg_value;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s expected %h actual %h", name, expected, actual);
      $display("tests failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic check_outputs(input string name);
    exu_pkg::word_t alu;
    alu = alu_ref(m_op, m_opnd1, m_opnd2);
    check_value({name, " alu_result"}, alu, alu_result);
    check_value({name, " npc"}, npc_ref(m_npc_sel, m_snpc, m_dnpc, alu), npc);
    check_value({name, " snpc"}, m_snpc, snpc);
    check_value({name, " exu_pc"}, m_pc, exu_pc);
    check_value({name, " exu_r_wdata"}, expected_wdata(), exu_r_wdata);
    check_value({name, " npc_valid"}, 32'(m_valid), 32'(npc_valid));
    check_value({name, " clear_pipeline"}, 32'(expected_flush()), 32'(clear_pipeline));
    check_value({name, " clear_cache"}, 32'(m_fence), 32'(clear_cache));
    if (prev_block) begin // The last edge was stalled, so nothing may have moved.
      check_value({name, " stall alu_result"}, held_alu, alu_result);
      check_value({name, " stall npc"}, held_npc, npc);
      check_value({name, " stall exu_r_wdata"}, held_wdata, exu_r_wdata);
      check_value({name, " stall exu_pc"}, held_pc, exu_pc);
    end
    held_alu = alu_result;
    held_npc = npc;
    held_wdata = exu_r_wdata;
    held_pc = exu_pc;
  endtask

  // Mode 0 alu, 1 bypass, 2 next pc, 3 squash, 4 fence, 5 stall.
  task automatic drive_inputs(input int mode);
    logic [31:0] r;
    logic [31:0] pc_word;
    r = rand_word();
    reset = 1'b0;
    decode_valid = r[31:29] != 3'd0;
    exception = (mode >= 3) && (r[28:26] == 3'd0);
    block = (mode == 5) ? r[22] : ((mode == 4) && (r[25:23] == 3'd0));
    fence_i = (mode >= 4) && (r[21:19] == 3'd0);
    alu_op = r[18:15];
    opnd1_sel = (mode == 0) ? exu_pkg::OPND_REG : r[14:13];
    if (opnd1_sel == exu_pkg::OPND_IMM) opnd1_sel = exu_pkg::OPND_REG;
    opnd2_sel = (mode == 0) ? {1'b0, r[12]} : r[12:11];
    npc_sel = (mode < 2) ? exu_pkg::NPC_SEQ : r[10:9];
    wb_sel = (mode < 2) ? exu_pkg::WB_ALU : r[8:7];
    src1 = rand_word();
    src2 = (r[6:5] == 2'd0) ? src1 : rand_word(); // Equal operands for the compares.
    imm = rand_word();
    forward_data = rand_word();
    csr_src = rand_word();
    pc_word = rand_word();
    idu_pc = {pc_word[31:2], 2'b00};
  endtask

  task automatic count_fence();
    if (clear_cache && !prev_cc) begin
      fence_len = 0;
      fences_seen++;
    end
    if (!clear_cache && prev_cc) check_value("fence length", FENCE_CYCLES, fence_len);
    if (clear_cache && !block) fence_len++;
    prev_cc = clear_cache;
    prev_block = block;
  endtask

  task automatic update_model();
    logic acc;
    exu_pkg::word_t o1;
    exu_pkg::word_t o2;
    acc = !m_fence && decode_valid && !exception && !expected_flush();
    o1 = select_operand(opnd1_sel, src1, src1);
    o2 = select_operand(opnd2_sel, src2, imm);
    if (reset) begin
      m_valid = 1'b0;
      m_fence = 1'b0;
      m_fence_left = 0;
    end
    if (!block) begin
      {m_op, m_opnd1, m_opnd2, m_pc, m_csr} = {alu_op, o1, o2, idu_pc, csr_src};
      m_snpc = idu_pc + 32'd4;
      m_dnpc = idu_pc + imm;
      m_npc_sel = npc_sel;
      m_wb_sel = wb_sel;
      if (!reset) begin
        m_valid = acc;
        if (m_fence) begin
          m_fence_left--;
          m_fence = m_fence_left != 0;
        end else if (acc && fence_i) begin
          m_fence = 1'b1;
          m_fence_left = FENCE_CYCLES;
        end
      end
    end
  endtask

  task automatic run_test(input string name, input int mode, input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clock);
      check_outputs(name);
      drive_inputs(mode);
      count_fence();
      @(posedge clock);
      update_model();
    end
  endtask

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clock);
      cycle_count++;
      if (cycle_count >= CYCLE_LIMIT) begin
        $display("timeout after %0d cycles, the run did not reach its end", cycle_count);
        $display("tests failed");
        $fatal(1, "cycle limit reached");
      end
    end
  end

  initial begin
    lcg_state = 32'd79966;
    {reset, block, decode_valid, fence_i, exception} = 5'b10000;
    {idu_pc, imm, src1, src2, forward_data, csr_src} = '0;
    {alu_op, opnd1_sel, opnd2_sel, npc_sel, wb_sel} = '0;
    {m_valid, m_fence, prev_cc, prev_block} = 4'b0000;
    {m_fence_left, fence_len, fences_seen} = {32'd0, 32'd0, 32'd0};
    repeat (RESET_CYCLES) begin
      @(posedge clock);
      update_model();
    end
    run_test("alu", 0, 200);
    run_test("bypass", 1, 200);
    run_test("next_pc", 2, 300);
    run_test("squash", 3, 200);
    run_test("fence", 4, 300);
    run_test("stall", 5, 200);
    if (fences_seen == 0) begin
      $display("no fence.i instruction raised clear_cache during the run");
      $display("tests failed");
      $fatal(1, "fence was never exercised");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

//--- list.f
common/exu_pkg.sv
common/exu_stage_if.sv
source/alu.sv
source/operand_select.sv
source/next_pc.sv
control/exu_control.sv
control/fence_timer.sv
source/execute_top.sv
verification/execute_tb.sv
+incdir+verification

//--- run.sh
#!/usr/bin/env bash
# Builds the execute stage testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f list.f --top-module execute_tb --Mdir build; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./build/Vexecute_tb 2>&1)"
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
  exit 0
fi

echo "pass message not found in the simulation output"
exit 1
